// File: cdi_glue_top.f
rtl/cdi_bus_pkg.sv
rtl/attex_decoder.sv
rtl/bus_response_mux.sv
rtl/in4_irq_owner.sv
rtl/slave_port_glue.sv
rtl/playcdi_rom.sv
rtl/cdi_glue_top.sv
sim/clock_gen.sv
sim/cdi_glue_tb.sv

// File: Bender.yml
package:
  name: cdi_glue

sources:
  - rtl/cdi_bus_pkg.sv
  - rtl/attex_decoder.sv
  - rtl/bus_response_mux.sv
  - rtl/in4_irq_owner.sv
  - rtl/slave_port_glue.sv
  - rtl/playcdi_rom.sv
  - rtl/cdi_glue_top.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/cdi_glue_tb.sv

// File: playcdi.mem
// One 16-bit ROM word per line in hex, word 0 sits at byte address F00000
4afc
0001
0000
006a
0000
0034
0555
0c01
8000
0000
0040
0048
0000
0100
0000
0050
4e75
7061
6c61
7963
6469
0000
48e7
c0c0
41fa
0024
7000
4e40
0084
4a40
6610
41fa
001c
7001
4e40
0006
4cdf
0303
4e75
2f64
6431
2f43
4449
5f46
494c
4500
2f64
642f
6364
695f
6170
7000
3f2a

// File: sim/cdi_glue_tb.sv
`timescale 1ns/1ns

module cdi_glue_tb;

    import cdi_bus_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int DECODE_CYCLES  = 2000;
    localparam int BUSERR_CYCLES  = 2000;
    localparam int READ_CYCLES    = 1000;
    localparam int IRQ_CYCLES     = 1000;
    localparam int SLAVE_CYCLES   = 1000;
    localparam int ROM_CYCLES     = 300;
    localparam int TIMEOUT_CYCLES = (RESET_CYCLES + DECODE_CYCLES + BUSERR_CYCLES + READ_CYCLES
                                     + IRQ_CYCLES + SLAVE_CYCLES + ROM_CYCLES) * 12 / 10;

    logic         clk30;
    logic         power_on_reset;
    logic         reset_pulse;
    logic         external_reset;
    cpu_bus_t     cpu;
    periph_resp_t cdic_resp;
    periph_resp_t vmpeg_resp;
    periph_resp_t mcd212_resp;
    periph_resp_t mk48_resp;
    logic         config_disable_vmpeg;
    logic         config_auto_play;
    logic         cd_img_mounted;
    logic         audio_cd_in_tray;
    logic         mpeg_ram_enabled;
    logic         cdic_intreq;
    logic         vmpeg_intreq;
    logic         iack4;
    slave_pins_t  slave;
    word_t        cpu_data_in;
    logic         bus_ack;
    logic         bus_err;
    logic         in2;
    logic         in4;
    logic         cdic_intack;
    logic         vmpeg_intack;
    logic         slave_irq;
    logic         slave_rts;
    logic         sys_reset;
    chip_sel_t    chip_sel;

    // Reference model state, updated on every rising edge
    word_t      rom_image [PLAYCDI_WORDS];
    in4_owner_e owner_m;
    logic       dtack_q_m;
    logic       sel_q_m;
    logic       rom_ack_m;
    word_t      rom_data_m;
    logic       slave_reset_m; // Last reset came from the slave

    int cycle_count = 0;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_run;
    int seed;

    assign external_reset = power_on_reset || reset_pulse;

    clock_gen clocks (.clk30, .reset(power_on_reset));

    cdi_glue_top uut (
        .clk30, .external_reset, .cpu, .cdic_resp, .vmpeg_resp, .mcd212_resp, .mk48_resp,
        .config_disable_vmpeg, .config_auto_play, .cd_img_mounted, .audio_cd_in_tray,
        .mpeg_ram_enabled, .cdic_intreq, .vmpeg_intreq, .iack4, .slave, .cpu_data_in,
        .bus_ack, .bus_err, .in2, .in4, .cdic_intack, .vmpeg_intack, .slave_irq, .slave_rts,
        .sys_reset, .chip_sel
    );

    always @(posedge clk30) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic in_range(input logic [23:0] a, input logic [23:0] lo,
                                      input logic [23:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    function automatic chip_sel_t decode_selects(input logic [23:0] a, input logic as,
                                                 input logic vmpeg_off, input logic rom_on);
        chip_sel_t s;
        s = '0;
        if (as) begin
            s.mcd212  = (a < 24'h280000) || in_range(a, 24'h400000, 24'h7fffff);
            s.dvc_ram = in_range(a, 24'hd00000, 24'hdfffff) || in_range(a, 24'he80000, 24'hefffff);
            s.dvc_rom = in_range(a, 24'he40000, 24'he7ffff);
            s.mpeg    = in_range(a, 24'he00000, 24'he3ffff) && !vmpeg_off;
            s.cdic    = (a[23:16] == 8'h30);
            s.slave   = (a[23:16] == 8'h31);
            s.mk48    = (a[23:16] == 8'h32);
            s.playcdi = in_range(a, 24'hf00000, 24'hf00068) && rom_on;
        end
        return s;
    endfunction

    function automatic logic bus_error_model(input logic [23:0] a, input cpu_bus_t c,
                                             input logic ram_on, input logic rom_on);
        logic hole;
        hole = in_range(a, 24'h080000, 24'h1fffff) || in_range(a, 24'h500000, 24'hcfffff)
               || (a >= 24'hf10000);
        return c.as && (c.uds || c.lds) && (hole || ((a >= 24'hf00000) && !rom_on)
               || (in_range(a, 24'he80000, 24'hefffff) && !ram_on));
    endfunction

    function automatic logic rom_enabled();
        return cd_img_mounted && config_auto_play && !audio_cd_in_tray && !slave_reset_m;
    endfunction

    function automatic logic resetsys_level();
        return slave.ddrc[2] ? slave.portc_out[2] : 1'b0;
    endfunction

    function automatic logic dtack_level();
        return slave.ddrb[6] ? slave.portb_out[6] : 1'b1; // Pulled high as an input
    endfunction

    // Peripheral pages get most of the hits, the rest is spread over the map
    function automatic logic [23:0] random_addr();
        logic [7:0]  page;
        logic [15:0] low;
        low = 16'($urandom);
        case ($urandom_range(19))
            0:  page = 8'h00;
            1:  page = 8'h08;
            2:  page = 8'h1f;
            3:  page = 8'h27;
            4:  page = 8'h28;
            5:  page = 8'h30;
            6:  page = 8'h31;
            7:  page = 8'h32;
            8:  page = 8'h40;
            9:  page = 8'h50;
            10: page = 8'hd0;
            11: page = 8'he0;
            12: page = 8'he4;
            13: page = 8'he8;
            14: page = 8'hf0;
            15: page = 8'hf1;
            default: page = 8'($urandom);
        endcase
        if ((page == 8'hf0) && ($urandom_range(1) == 1)) low = 16'($urandom_range(16'h7f));
        return {page, low};
    endfunction

    function automatic periph_resp_t random_resp();
        return periph_resp_t'(17'($urandom));
    endfunction

    function automatic cpu_bus_t bus_access(input logic [23:0] a, input logic as,
                                            input logic uds, input logic lds);
        cpu_bus_t c;
        c.addr         = a[23:1];
        c.as           = as;
        c.uds          = uds;
        c.lds          = lds;
        c.write_strobe = 1'b0;
        c.data_out     = 16'($urandom);
        return c;
    endfunction

    // Runs in the active region of the edge, so the inputs still hold last cycle's values
    task automatic advance_model();
        logic [23:0] a;
        logic        rst;
        chip_sel_t   s;
        a   = {cpu.addr, 1'b0};
        rst = external_reset || resetsys_level();
        s   = decode_selects(a, cpu.as, config_disable_vmpeg, rom_enabled());
        rom_data_m = (a[6:1] < PLAYCDI_WORDS) ? rom_image[a[6:1]] : 16'h0000;
        if (rst) begin
            owner_m   = IDLE;
            dtack_q_m = 1'b0;
            sel_q_m   = 1'b0;
            rom_ack_m = 1'b0;
        end else begin
            case (owner_m)
                CDIC:    owner_m = cdic_intreq ? CDIC : IDLE;
                VMPEG:   owner_m = vmpeg_intreq ? VMPEG : IDLE;
                default: owner_m = vmpeg_intreq ? VMPEG : (cdic_intreq ? CDIC : IDLE);
            endcase
            dtack_q_m = dtack_level();
            sel_q_m   = s.slave;
            rom_ack_m = s.playcdi && !rom_ack_m;
        end
        if (external_reset) slave_reset_m = 1'b0;
        else if (resetsys_level()) slave_reset_m = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        logic [23:0] a;
        chip_sel_t   s;
        word_t       data_e;
        logic        ack_e;
        logic        cdic_ack_e;
        logic        vmpeg_ack_e;
        a           = {cpu.addr, 1'b0};
        s           = decode_selects(a, cpu.as, config_disable_vmpeg, rom_enabled());
        cdic_ack_e  = iack4 && (owner_m == CDIC);
        vmpeg_ack_e = iack4 && (owner_m == VMPEG);
        data_e      = 16'h0000;
        ack_e       = 1'b1; // Nothing selected
        if (s.slave) begin
            data_e = 16'h0000; // Slave byte is zero here, replicated stays zero
            ack_e  = dtack_level() && !dtack_q_m;
        end else if (s.cdic) begin
            data_e = cdic_resp.dout;
            ack_e  = cdic_resp.bus_ack;
        end else if (s.mpeg) begin
            data_e = vmpeg_resp.dout;
            ack_e  = vmpeg_resp.bus_ack;
        end else if (s.mk48) begin
            data_e = {mk48_resp.dout[7:0], mk48_resp.dout[7:0]};
            ack_e  = mk48_resp.bus_ack;
        end else if (s.mcd212 || s.dvc_ram || s.dvc_rom) begin
            data_e = mcd212_resp.dout;
            ack_e  = mcd212_resp.bus_ack;
        end else if (s.playcdi) begin
            data_e = rom_data_m;
            ack_e  = rom_ack_m;
        end
        if (cdic_ack_e) begin
            data_e = cdic_resp.dout;
            ack_e  = 1'b1;
        end
        if (vmpeg_ack_e) begin
            data_e = vmpeg_resp.dout;
            ack_e  = 1'b1;
        end
        check_value("chip_sel", chip_sel, s);
        check_value("bus_err", bus_err, bus_error_model(a, cpu, mpeg_ram_enabled, rom_enabled()));
        check_value("cpu_data_in", cpu_data_in, data_e);
        check_value("bus_ack", bus_ack, ack_e);
        check_value("in4", in4, ((owner_m == CDIC) && cdic_intreq)
                                || ((owner_m == VMPEG) && vmpeg_intreq));
        check_value("cdic_intack", cdic_intack, cdic_ack_e);
        check_value("vmpeg_intack", vmpeg_intack, vmpeg_ack_e);
        check_value("in2", in2, slave.ddrb[5] ? !slave.portb_out[5] : 1'b0);
        check_value("slave_rts", slave_rts, slave.ddrb[4] ? slave.portb_out[4] : 1'b1);
        check_value("slave_irq", slave_irq, s.slave && !sel_q_m);
        check_value("sys_reset", sys_reset, external_reset || resetsys_level());
    endtask

    task automatic next_cycle();
        @(posedge clk30);
        advance_model();
    endtask

    task automatic settle_and_check();
        @(negedge clk30);
        check_outputs();
    endtask

    task automatic drive_bus_mix(input bit vary_ram_lock);
        cpu                  <= bus_access(random_addr(), 1'($urandom), 1'($urandom),
                                           1'($urandom));
        config_disable_vmpeg <= ($urandom_range(3) == 0);
        cd_img_mounted       <= ($urandom_range(3) != 0);
        config_auto_play     <= ($urandom_range(3) != 0);
        audio_cd_in_tray     <= ($urandom_range(3) == 0);
        cdic_resp            <= random_resp();
        vmpeg_resp           <= random_resp();
        mcd212_resp          <= random_resp();
        mk48_resp            <= random_resp();
        if (vary_ram_lock) mpeg_ram_enabled <= 1'($urandom);
    endtask

    // Select one word, wait for its ack and compare with the image
    task automatic read_rom_word(input int index);
        int waited;
        next_cycle();
        cpu <= bus_access(PLAYCDI_BASE + 24'(2 * index), 1'b1, 1'b1, 1'b1);
        settle_and_check();
        waited = 0;
        while (!bus_ack && (waited < 4)) begin
            next_cycle();
            settle_and_check();
            waited++;
        end
        assert (bus_ack) else begin
            $display("ROM word %0d was not acknowledged within 4 cycles", index);
            test_errors++;
        end
        if (bus_ack) begin
            check_value("rom ack latency", waited, 1);
            check_value("cpu_data_in", cpu_data_in, rom_image[index]);
        end
        next_cycle();
        cpu.as <= 1'b0;
        settle_and_check();
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        slave_pins_t pins;
        seed = $urandom(32'h5d5c);
        $readmemh("playcdi.mem", rom_image);
        test_checks          = 0;
        test_errors          = 0;
        total_checks         = 0;
        total_errors         = 0;
        tests_run            = 0;
        reset_pulse          = 1'b0;
        cpu                  = '0;
        cdic_resp            = '0;
        vmpeg_resp           = '0;
        mcd212_resp          = '0;
        mk48_resp            = '0;
        config_disable_vmpeg = 1'b0;
        config_auto_play     = 1'b0;
        cd_img_mounted       = 1'b0;
        audio_cd_in_tray     = 1'b0;
        mpeg_ram_enabled     = 1'b1;
        cdic_intreq          = 1'b0;
        vmpeg_intreq         = 1'b0;
        iack4                = 1'b0;
        slave                = '0;

        do begin
            next_cycle();
            @(negedge clk30);
        end while (power_on_reset);

        repeat (DECODE_CYCLES) begin
            next_cycle();
            drive_bus_mix(1'b0);
            settle_and_check();
        end
        finish_test("decode");

        repeat (BUSERR_CYCLES) begin
            next_cycle();
            drive_bus_mix(1'b1);
            settle_and_check();
        end
        finish_test("bus error");

        repeat (READ_CYCLES) begin
            next_cycle();
            drive_bus_mix(1'b1);
            cdic_intreq  <= 1'($urandom);
            vmpeg_intreq <= 1'($urandom);
            iack4        <= ($urandom_range(3) == 0); // Some vector fetches
            settle_and_check();
        end
        finish_test("read path");

        repeat (IRQ_CYCLES) begin
            next_cycle();
            cpu.as <= 1'b0;
            if ($urandom_range(3) == 0) cdic_intreq <= !cdic_intreq;
            if ($urandom_range(3) == 0) vmpeg_intreq <= !vmpeg_intreq;
            iack4 <= 1'($urandom);
            settle_and_check();
        end
        finish_test("level-4 owner");

        repeat (SLAVE_CYCLES) begin
            next_cycle();
            pins              = slave_pins_t'($urandom);
            pins.portc_out[2] = ($urandom_range(7) == 0); // Slave resets stay rare
            slave <= pins;
            cpu   <= bus_access(($urandom_range(1) == 1) ? {8'h31, 16'($urandom)} : random_addr(),
                                1'($urandom), 1'b1, 1'b1);
            iack4 <= 1'b0;
            settle_and_check();
        end
        finish_test("slave pins");

        // Clear the slave reset latch first
        next_cycle();
        slave        <= '0;
        cpu          <= bus_access(24'h000000, 1'b0, 1'b0, 1'b0);
        cdic_intreq  <= 1'b0;
        vmpeg_intreq <= 1'b0;
        reset_pulse  <= 1'b1;
        settle_and_check();
        next_cycle();
        reset_pulse <= 1'b0;
        settle_and_check();
        for (int combo = 0; combo < 8; combo++) begin
            next_cycle();
            cd_img_mounted   <= combo[0];
            config_auto_play <= combo[1];
            audio_cd_in_tray <= combo[2];
            cpu              <= bus_access(PLAYCDI_BASE + 24'(2 * combo), 1'b1, 1'b1, 1'b1);
            settle_and_check();
            next_cycle();
            settle_and_check();
        end
        next_cycle();
        cd_img_mounted   <= 1'b1;
        config_auto_play <= 1'b1;
        audio_cd_in_tray <= 1'b0;
        cpu.as           <= 1'b0;
        slave.ddrc       <= 8'h04;
        slave.portc_out  <= 8'h04; // Slave drives resetsys
        settle_and_check();
        next_cycle();
        slave <= '0;
        settle_and_check();
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            cpu <= bus_access(PLAYCDI_BASE + 24'(2 * i), 1'b1, 1'b0, 1'b1);
            settle_and_check();
            check_value("bus_err", bus_err, 1'b1);
            check_value("chip_sel.playcdi", chip_sel.playcdi, 1'b0);
        end
        next_cycle();
        cpu.as      <= 1'b0;
        reset_pulse <= 1'b1;
        settle_and_check();
        next_cycle();
        reset_pulse <= 1'b0;
        settle_and_check();
        for (int i = 0; i < PLAYCDI_WORDS; i++) begin
            read_rom_word(i);
        end
        finish_test("auto-play rom");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk30,
    output logic reset
);

    localparam int HALF_PERIOD  = 20; // 40 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        clk30 = 1'b0;
        forever #HALF_PERIOD clk30 = ~clk30;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk30);
        reset <= 1'b0;
    end

endmodule

// File: rtl/cdi_glue_top.sv
`timescale 1ns/1ns

module cdi_glue_top (
    input  logic                      clk30,
    input  logic                      external_reset,
    input  cdi_bus_pkg::cpu_bus_t     cpu,
    input  cdi_bus_pkg::periph_resp_t cdic_resp,
    input  cdi_bus_pkg::periph_resp_t vmpeg_resp,
    input  cdi_bus_pkg::periph_resp_t mcd212_resp,
    input  cdi_bus_pkg::periph_resp_t mk48_resp,
    input  logic                      config_disable_vmpeg,
    input  logic                      config_auto_play,
    input  logic                      cd_img_mounted,
    input  logic                      audio_cd_in_tray,
    input  logic                      mpeg_ram_enabled,
    input  logic                      cdic_intreq,
    input  logic                      vmpeg_intreq,
    input  logic                      iack4,
    input  cdi_bus_pkg::slave_pins_t  slave,
    output cdi_bus_pkg::word_t        cpu_data_in,
    output logic                      bus_ack,
    output logic                      bus_err,
    output logic                      in2,
    output logic                      in4,
    output logic                      cdic_intack,
    output logic                      vmpeg_intack,
    output logic                      slave_irq,
    output logic                      slave_rts,
    output logic                      sys_reset,
    output cdi_bus_pkg::chip_sel_t    chip_sel
);

    import cdi_bus_pkg::*;

    periph_resp_t slave_resp;
    periph_resp_t rom_resp;
    logic         resetsys;
    logic         playcdi_active;

    assign sys_reset = external_reset || resetsys; // Slave can reset the whole system

    attex_decoder decoder (
        .cpu, .config_disable_vmpeg, .mpeg_ram_enabled, .playcdi_active,
        .sel(chip_sel), .bus_err
    );

    bus_response_mux resp_mux (
        .sel(chip_sel), .cdic_resp, .vmpeg_resp, .mcd212_resp, .mk48_resp,
        .slave_resp, .rom_resp, .cdic_intack, .vmpeg_intack, .cpu_data_in, .bus_ack
    );

    in4_irq_owner irq_owner (
        .clk30, .reset(sys_reset), .cdic_intreq, .vmpeg_intreq, .iack4,
        .in4, .cdic_intack, .vmpeg_intack
    );

    slave_port_glue slave_glue (
        .clk30, .reset(sys_reset), .pins(slave), .slave_sel(chip_sel.slave),
        .slave_resp, .resetsys, .slave_rts, .in2, .slave_irq
    );

    playcdi_rom boot_rom (
        .clk30, .external_reset, .reset(sys_reset), .resetsys, .rom_sel(chip_sel.playcdi),
        .cd_img_mounted, .config_auto_play, .audio_cd_in_tray,
        .word_index(cpu.addr[6:1]), .rom_resp, .playcdi_active
    );

endmodule

// File: rtl/playcdi_rom.sv
`timescale 1ns/1ns

module playcdi_rom (
    input  logic                                  clk30,
    input  logic                                  external_reset,
    input  logic                                  reset,
    input  logic                                  resetsys,
    input  logic                                  rom_sel,
    input  logic                                  cd_img_mounted,
    input  logic                                  config_auto_play,
    input  logic                                  audio_cd_in_tray,
    input  logic [cdi_bus_pkg::PLAYCDI_AW-1:0]    word_index,
    output cdi_bus_pkg::periph_resp_t             rom_resp,
    output logic                                  playcdi_active
);

    import cdi_bus_pkg::*;

    word_t rom [PLAYCDI_WORDS];
    word_t rom_dout;
    logic  rom_ack;
    logic  last_reset_by_slave;

    initial $readmemh("playcdi.mem", rom); // OS-9 module that starts the disc application

    // A reset from the slave means the title quit to the shell, so stay there
    always_ff @(posedge clk30) begin
        if (external_reset) last_reset_by_slave <= 1'b0;
        else if (resetsys) last_reset_by_slave <= 1'b1;
    end

    assign playcdi_active = cd_img_mounted && config_auto_play && !audio_cd_in_tray
                            && !last_reset_by_slave;

    always_ff @(posedge clk30) begin
        if (word_index < PLAYCDI_WORDS) rom_dout <= rom[word_index];
        else rom_dout <= '0;
    end

    always_ff @(posedge clk30) begin
        if (reset) rom_ack <= 1'b0;
        else rom_ack <= rom_sel && !rom_ack; // One wait state per word
    end

    assign rom_resp.dout    = rom_dout;
    assign rom_resp.bus_ack = rom_ack;

    ack_single_cycle: assert property (@(posedge clk30) disable iff (reset) rom_ack |=> !rom_ack);

endmodule

// File: rtl/slave_port_glue.sv
`timescale 1ns/1ns

module slave_port_glue (
    input  logic                      clk30,
    input  logic                      reset,
    input  cdi_bus_pkg::slave_pins_t  pins,
    input  logic                      slave_sel,
    output cdi_bus_pkg::periph_resp_t slave_resp,
    output logic                      resetsys,
    output logic                      slave_rts,
    output logic                      in2,
    output logic                      slave_irq
);

    import cdi_bus_pkg::*;

    logic dtack_pin;
    logic in2_pin;
    logic dtack_q;
    logic slave_sel_q;

    // An input pin floats to the level of its pull resistor
    function automatic logic pin_level(input logic dir, input logic level, input logic idle);
        return dir ? level : idle;
    endfunction

    assign resetsys  = pin_level(pins.ddrc[2], pins.portc_out[2], 1'b0);
    assign slave_rts = pin_level(pins.ddrb[4], pins.portb_out[4], 1'b1);
    assign in2_pin   = pin_level(pins.ddrb[5], pins.portb_out[5], 1'b1);
    assign dtack_pin = pin_level(pins.ddrb[6], pins.portb_out[6], 1'b1);

    // The CPU input is active low on the real board
    assign in2 = !in2_pin;

    always_ff @(posedge clk30) begin
        if (reset) begin
            dtack_q     <= 1'b0;
            slave_sel_q <= 1'b0;
        end else begin
            dtack_q     <= dtack_pin;
            slave_sel_q <= slave_sel;
        end
    end

    // Acknowledge on the rising edge of the slave DTACK pin
    assign slave_resp.bus_ack = dtack_pin && !dtack_q;
    assign slave_resp.dout    = '0; // Read data comes from port A outside this block

    // Wake the slave once per access
    assign slave_irq = slave_sel && !slave_sel_q;

endmodule

// File: rtl/in4_irq_owner.sv
`timescale 1ns/1ns

module in4_irq_owner (
    input  logic clk30,
    input  logic reset,
    input  logic cdic_intreq,
    input  logic vmpeg_intreq,
    input  logic iack4,
    output logic in4,
    output logic cdic_intack,
    output logic vmpeg_intack
);

    import cdi_bus_pkg::*;

    in4_owner_e owner;

    // Works like the small SR flip-flop on the board, first requester keeps the line
    always_ff @(posedge clk30) begin
        if (reset) begin
            owner <= IDLE;
        end else begin
            case (owner)
                CDIC:    if (!cdic_intreq) owner <= IDLE;
                VMPEG:   if (!vmpeg_intreq) owner <= IDLE;
                default: begin
                    if (vmpeg_intreq) owner <= VMPEG; // MPEG takes precedence on a tie
                    else if (cdic_intreq) owner <= CDIC;
                end
            endcase
        end
    end

    assign in4          = ((owner == CDIC) && cdic_intreq) || ((owner == VMPEG) && vmpeg_intreq);
    assign cdic_intack  = iack4 && (owner == CDIC);
    assign vmpeg_intack = iack4 && (owner == VMPEG);

    intack_exclusive: assert property (@(posedge clk30) disable iff (reset)
        !(cdic_intack && vmpeg_intack));

endmodule

// File: rtl/bus_response_mux.sv
`timescale 1ns/1ns

module bus_response_mux (
    input  cdi_bus_pkg::chip_sel_t    sel,
    input  cdi_bus_pkg::periph_resp_t cdic_resp,
    input  cdi_bus_pkg::periph_resp_t vmpeg_resp,
    input  cdi_bus_pkg::periph_resp_t mcd212_resp,
    input  cdi_bus_pkg::periph_resp_t mk48_resp,
    input  cdi_bus_pkg::periph_resp_t slave_resp,
    input  cdi_bus_pkg::periph_resp_t rom_resp,
    input  logic                      cdic_intack,
    input  logic                      vmpeg_intack,
    output cdi_bus_pkg::word_t        cpu_data_in,
    output logic                      bus_ack
);

    import cdi_bus_pkg::*;

    logic mcd212_group;

    assign mcd212_group = sel.mcd212 || sel.dvc_ram || sel.dvc_rom; // All answered by the VDSC

    always_comb begin
        cpu_data_in = '0;
        bus_ack     = 1'b1; // Unselected cycles finish at once

        if (sel.slave) begin
            cpu_data_in = {slave_resp.dout[7:0], slave_resp.dout[7:0]};
            bus_ack     = slave_resp.bus_ack;
        end else if (sel.cdic) begin
            cpu_data_in = cdic_resp.dout;
            bus_ack     = cdic_resp.bus_ack;
        end else if (sel.mpeg) begin
            cpu_data_in = vmpeg_resp.dout;
            bus_ack     = vmpeg_resp.bus_ack;
        end else if (sel.mk48) begin
            cpu_data_in = {mk48_resp.dout[7:0], mk48_resp.dout[7:0]}; // 8 bit device on both lanes
            bus_ack     = mk48_resp.bus_ack;
        end else if (mcd212_group) begin
            cpu_data_in = mcd212_resp.dout;
            bus_ack     = mcd212_resp.bus_ack;
        end else if (sel.playcdi) begin
            cpu_data_in = rom_resp.dout;
            bus_ack     = rom_resp.bus_ack;
        end

        // Vector fetch during level 4 acknowledge, MPEG checked last so it wins
        if (cdic_intack) begin
            cpu_data_in = cdic_resp.dout;
            bus_ack     = 1'b1;
        end
        if (vmpeg_intack) begin
            cpu_data_in = vmpeg_resp.dout;
            bus_ack     = 1'b1;
        end
    end

endmodule

// File: rtl/attex_decoder.sv
`timescale 1ns/1ns

module attex_decoder (
    input  cdi_bus_pkg::cpu_bus_t  cpu,
    input  logic                   config_disable_vmpeg,
    input  logic                   mpeg_ram_enabled,
    input  logic                   playcdi_active,
    output cdi_bus_pkg::chip_sel_t sel,
    output logic                   bus_err
);

    import cdi_bus_pkg::*;

    byte_addr_t addr_byte;
    logic       in_mcd212;
    logic       in_playcdi;
    logic       err_hole;
    logic       err_rom;
    logic       err_mpeg_ram;

    assign addr_byte = {cpu.addr, 1'b0};

    // Main video RAM below and above the peripheral window, lower half of the map only
    assign in_mcd212 = ((addr_byte <= MCD212_LOW_END) || (addr_byte >= MCD212_HIGH_START))
                       && !addr_byte[23];
    assign in_playcdi = (addr_byte >= PLAYCDI_BASE) && (addr_byte <= PLAYCDI_LAST);

    always_comb begin
        sel.mcd212  = in_mcd212 && cpu.as;
        sel.dvc_ram = ((addr_byte[23:20] == DVC_RAM_PAGE) || (addr_byte[23:19] == MPEG_RAM_PAGE))
                      && cpu.as;
        sel.dvc_rom = (addr_byte[23:18] == DVC_ROM_PAGE) && cpu.as;
        sel.mpeg    = (addr_byte[23:18] == MPEG_REG_PAGE) && cpu.as && !config_disable_vmpeg;
        sel.cdic    = (addr_byte[23:16] == CDIC_PAGE) && cpu.as;
        sel.slave   = (addr_byte[23:16] == SLAVE_PAGE) && cpu.as;
        sel.mk48    = (addr_byte[23:16] == MK48_PAGE) && cpu.as;
        sel.playcdi = in_playcdi && playcdi_active && cpu.as;
    end

    assign err_hole = ((addr_byte >= ERR1_LO) && (addr_byte <= ERR1_HI))
                   || ((addr_byte >= ERR2_LO) && (addr_byte <= ERR2_HI))
                   || (addr_byte >= ERR3_LO);
    assign err_rom      = (addr_byte >= PLAYCDI_BASE) && !playcdi_active;
    assign err_mpeg_ram = (addr_byte[23:19] == MPEG_RAM_PAGE) && !mpeg_ram_enabled; // Locked after boot

    // Only a real data phase raises the error
    assign bus_err = (err_hole || err_rom || err_mpeg_ram) && cpu.as && (cpu.lds || cpu.uds);

    // Peripheral pages must never overlap, the response mux relies on it
    always_comb begin
        periph_sel_exclusive: assert final ($onehot0({sel.cdic, sel.slave, sel.mk48, sel.mpeg}));
    end

endmodule

// File: rtl/cdi_bus_pkg.sv
package cdi_bus_pkg;

    typedef logic [15:0] word_t;      // CPU data word
    typedef logic [7:0]  byte_t;      // Port or NVRAM byte
    typedef logic [23:1] word_addr_t; // CPU word address, A0 is implied by the strobes
    typedef logic [23:0] byte_addr_t;

    typedef struct packed {
        word_addr_t addr;
        logic       as;
        logic       uds;
        logic       lds;
        logic       write_strobe;
        word_t      data_out;
    } cpu_bus_t;

    typedef struct packed {
        word_t dout;
        logic  bus_ack;
    } periph_resp_t;

    typedef struct packed {
        logic mcd212;
        logic dvc_ram;
        logic dvc_rom;
        logic mpeg;
        logic cdic;
        logic slave;
        logic mk48;
        logic playcdi;
    } chip_sel_t;

    typedef struct packed {
        byte_t portb_out;
        byte_t portc_out;
        byte_t ddrb;
        byte_t ddrc;
    } slave_pins_t;

    typedef enum logic [1:0] {IDLE, CDIC, VMPEG} in4_owner_e;

    // Address map
    localparam byte_addr_t MCD212_LOW_END    = 24'h27ffff;
    localparam byte_addr_t MCD212_HIGH_START = 24'h400000;
    localparam byte_t      CDIC_PAGE         = 8'h30;
    localparam byte_t      SLAVE_PAGE        = 8'h31;
    localparam byte_t      MK48_PAGE         = 8'h32;
    localparam byte_addr_t PLAYCDI_BASE      = 24'hf00000;
    localparam byte_addr_t PLAYCDI_LAST      = 24'hf00068;

    // DVC cartridge space, matched on the upper address bits
    localparam logic [3:0] DVC_RAM_PAGE  = 4'hd;      // A23..A20
    localparam logic [4:0] MPEG_RAM_PAGE = 5'b11101;  // A23..A19
    localparam logic [5:0] DVC_ROM_PAGE  = 6'b111001; // A23..A18
    localparam logic [5:0] MPEG_REG_PAGE = 6'b111000; // A23..A18

    // Unmapped holes
    localparam byte_addr_t ERR1_LO = 24'h080000;
    localparam byte_addr_t ERR1_HI = 24'h1fffff;
    localparam byte_addr_t ERR2_LO = 24'h500000;
    localparam byte_addr_t ERR2_HI = 24'hcfffff;
    localparam byte_addr_t ERR3_LO = 24'hf10000;

    localparam int PLAYCDI_WORDS = 53;
    localparam int PLAYCDI_AW    = 6;

endpackage
